//--- verilog/entropy_pkg.sv
package entropy_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 18;
	localparam int WINDOW_W = 32;
	localparam int COEF_W = 16;
	localparam int BLOCK_SIZE = 64;
	localparam int IDX_W = 6;
	localparam int FILL_W = $clog2(WINDOW_W + 1); // Holds 0 to WINDOW_W

	typedef logic signed [COEF_W-1:0] coef_t;

	typedef enum logic [2:0] {
		PAIR3,
		SINGLE3,
		SINGLE6,
		END_ZEROS,
		SINGLE9,
		ZERO_RUN
	} code_kind_t;

	// Scan index to row-major position
	localparam logic [IDX_W-1:0] ZIGZAG [BLOCK_SIZE] = '{
		 0,  1,  8, 16,  9,  2,  3, 10,
		17, 24, 32, 25, 18, 11,  4,  5,
		12, 19, 26, 33, 40, 48, 41, 34,
		27, 20, 13,  6,  7, 14, 21, 28,
		35, 42, 49, 56, 57, 50, 43, 36,
		29, 22, 15, 23, 30, 37, 44, 51,
		58, 59, 52, 45, 38, 31, 39, 46,
		53, 60, 61, 54, 47, 55, 62, 63
	};

	// Shift exponents by table and row-major position, one row of the block per line
	localparam logic [2:0] QUANT_EXP [2][BLOCK_SIZE] = '{
		'{
			3, 3, 3, 3, 4, 4, 4, 4,
			3, 3, 3, 4, 4, 4, 4, 5,
			3, 3, 4, 4, 4, 4, 5, 5,
			3, 4, 4, 4, 4, 5, 5, 5,
			4, 4, 4, 4, 5, 5, 5, 5,
			4, 4, 4, 5, 5, 5, 5, 6,
			4, 4, 5, 5, 5, 5, 6, 6,
			4, 5, 5, 5, 5, 6, 6, 6
		},
		'{
			1, 1, 2, 2, 3, 3, 4, 4,
			1, 2, 2, 3, 3, 4, 4, 5,
			2, 2, 3, 3, 4, 4, 5, 5,
			2, 3, 3, 4, 4, 5, 5, 6,
			3, 3, 4, 4, 5, 5, 6, 6,
			3, 4, 4, 5, 5, 6, 6, 6,
			4, 4, 5, 5, 6, 6, 6, 6,
			4, 5, 5, 6, 6, 6, 6, 6
		}
	};

endpackage

//--- verilog/bit_stream_if.sv
interface bit_stream_if;
	import entropy_pkg::*;

	logic [WINDOW_W-1:0] window; // Oldest bit at the top
	logic [FILL_W-1:0] fill;
	logic consume;
	logic [FILL_W-1:0] consume_len;

	modport producer (
		output window,
		output fill,
		input  consume,
		input  consume_len
	);

	modport consumer (
		input  window,
		input  fill,
		output consume,
		output consume_len
	);

endinterface

//--- verilog/bit_window.sv
module bit_window #(
	parameter int MEM_LATENCY = 2
) (
	input  logic Clock,
	input  logic Resetn,
	output logic [entropy_pkg::ADDR_W-1:0] mem_addr,
	output logic mem_rd,
	input  logic [entropy_pkg::WORD_W-1:0] mem_data,
	bit_stream_if.producer win
);
	import entropy_pkg::*;

	logic [WINDOW_W-1:0] window;
	logic [FILL_W-1:0] fill;
	logic [1:0] in_flight;
	logic [MEM_LATENCY-1:0] valid_pipe;
	logic arrive;
	logic issue;
	logic [FILL_W-1:0] kept;
	logic [WINDOW_W-1:0] shifted;
	logic [WINDOW_W-1:0] incoming;

	assign arrive = valid_pipe[MEM_LATENCY-1];

	// Words still in flight count as full words, so the window can never overflow
	assign issue = (7'(fill) + 7'({in_flight, 4'd0})) <= 7'(WORD_W);

	assign kept = win.consume ? fill - win.consume_len : fill;
	assign shifted = win.consume ? window << win.consume_len : window;

	// New word lands right below the bits that survive this cycle's consume
	assign incoming = {mem_data, {(WINDOW_W - WORD_W){1'b0}}} >> kept;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			window <= '0;
			fill <= '0;
			in_flight <= '0;
			valid_pipe <= '0;
			mem_rd <= 1'b0;
			mem_addr <= '0;
		end else begin
			mem_rd <= issue;
			if (mem_rd) begin
				mem_addr <= mem_addr + 1'b1; // Points at the next unread word
			end
			valid_pipe <= (valid_pipe << 1) | MEM_LATENCY'(mem_rd);
			in_flight <= in_flight + 2'(issue) - 2'(arrive);

			if (arrive) begin
				window <= shifted | incoming;
				fill <= kept + FILL_W'(WORD_W);
			end else begin
				window <= shifted;
				fill <= kept;
			end
		end
	end

	assign win.window = window;
	assign win.fill = fill;

	// Read accounting must keep every merge inside the window
	a_fill_bound: assert property (
		@(posedge Clock) disable iff (!Resetn)
		fill <= FILL_W'(WINDOW_W)
	);

endmodule

//--- verilog/vlc_decoder.sv
module vlc_decoder (
	input  logic Clock,
	input  logic Resetn,
	input  logic hold,
	bit_stream_if.consumer win,
	output logic code_valid,
	output entropy_pkg::code_kind_t code_kind,
	output entropy_pkg::coef_t value_a,
	output entropy_pkg::coef_t value_b,
	output logic [3:0] run_len
);
	import entropy_pkg::*;

	localparam int MAX_CODE_LEN = 13;

	logic [WINDOW_W-1:0] w;
	code_kind_t kind;
	logic [FILL_W-1:0] len;
	coef_t a;
	coef_t b;
	logic [3:0] n;
	logic go;

	assign w = win.window;

	always_comb begin
		kind = SINGLE3;
		len = FILL_W'(5);
		a = '0;
		b = '0;
		n = 4'd0;
		casez (w[31:28])
			4'b00??: begin
				kind = PAIR3;
				len = FILL_W'(8);
				a = {{(COEF_W - 3){w[29]}}, w[29:27]};
				b = {{(COEF_W - 3){w[26]}}, w[26:24]};
			end
			4'b01??: begin
				a = {{(COEF_W - 3){w[29]}}, w[29:27]};
			end
			4'b100?: begin
				kind = SINGLE6;
				len = FILL_W'(9);
				a = {{(COEF_W - 6){w[28]}}, w[28:23]};
			end
			4'b1010: begin
				kind = END_ZEROS;
				len = FILL_W'(4);
			end
			4'b1011: begin
				kind = SINGLE9;
				len = FILL_W'(13);
				a = {{(COEF_W - 9){w[27]}}, w[27:19]};
			end
			default: begin
				kind = ZERO_RUN;
				n = (w[29:27] == 3'd0) ? 4'd8 : {1'b0, w[29:27]}; // Count of 0 stands for 8
			end
		endcase
	end

	// Any code fits once the window holds the longest one
	assign go = !hold && (win.fill >= FILL_W'(MAX_CODE_LEN));
	assign win.consume = go;
	assign win.consume_len = len;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= go;
		end
	end

	always_ff @(posedge Clock) begin
		if (go) begin
			code_kind <= kind;
			value_a <= a;
			value_b <= b;
			run_len <= n;
		end
	end

	a_consume_fits: assert property (
		@(posedge Clock) disable iff (!Resetn)
		win.consume |-> win.consume_len <= win.fill
	);

endmodule

//--- verilog/coeff_sequencer.sv
module coeff_sequencer (
	input  logic Clock,
	input  logic Resetn,
	input  logic start,
	input  logic code_valid,
	input  entropy_pkg::code_kind_t code_kind,
	input  entropy_pkg::coef_t value_a,
	input  entropy_pkg::coef_t value_b,
	input  logic [3:0] run_len,
	output logic hold,
	output logic coef_valid,
	output logic [entropy_pkg::IDX_W-1:0] coef_index,
	output entropy_pkg::coef_t coef_value,
	output logic block_ready
);
	import entropy_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_DECODE,
		S_PAIR2,
		S_RUN,
		S_FILL,
		S_READY
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic [IDX_W-1:0] scan;
	logic [3:0] zero_left;
	logic emit;
	coef_t emit_value;
	logic last;

	assign last = (scan == IDX_W'(BLOCK_SIZE - 1));

	always_comb begin
		state_next = state;
		emit = 1'b0;
		emit_value = '0;
		case (state)
			S_IDLE, S_READY: begin
				if (start) state_next = S_DECODE;
			end
			S_DECODE: begin
				if (code_valid) begin
					emit = 1'b1;
					emit_value = value_a;
					case (code_kind)
						PAIR3: state_next = S_PAIR2;
						END_ZEROS: begin
							emit_value = '0;
							state_next = S_FILL;
						end
						ZERO_RUN: begin
							emit_value = '0;
							if (run_len != 4'd1) state_next = S_RUN;
						end
						default: ;
					endcase
				end
			end
			S_PAIR2: begin
				emit = 1'b1;
				emit_value = value_b;
				state_next = S_DECODE;
			end
			S_RUN: begin
				emit = 1'b1;
				if (zero_left == 4'd1) state_next = S_DECODE;
			end
			S_FILL: emit = 1'b1;
			default: state_next = S_IDLE;
		endcase
		if (emit && last) state_next = S_READY; // Anything left of the code is dropped
	end

	// The decoder runs only when a fresh code can be taken on the next cycle
	assign hold = (state_next != S_DECODE);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			scan <= '0;
			zero_left <= 4'd0;
			coef_valid <= 1'b0;
			block_ready <= 1'b0;
		end else begin
			state <= state_next;
			coef_valid <= emit;
			block_ready <= (state_next == S_READY);
			if (emit) scan <= scan + 1'b1; // Wraps to 0 for the next block
			if (state == S_DECODE && code_valid && code_kind == ZERO_RUN) begin
				zero_left <= run_len - 4'd1;
			end else if (state == S_RUN) begin
				zero_left <= zero_left - 4'd1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (emit) begin
			coef_index <= scan;
			coef_value <= emit_value;
		end
	end

	// Back-to-back coefficients always belong to one block
	a_no_wrap: assert property (
		@(posedge Clock) disable iff (!Resetn)
		coef_valid && $past(coef_valid) |-> coef_index > $past(coef_index)
	);

endmodule

//--- verilog/dequantizer.sv
module dequantizer (
	input  logic Clock,
	input  logic start,
	input  logic q_select,
	input  logic coef_valid,
	input  logic [entropy_pkg::IDX_W-1:0] coef_index,
	input  entropy_pkg::coef_t coef_value,
	input  logic [entropy_pkg::IDX_W-1:0] rd_addr,
	output entropy_pkg::coef_t rd_data
);
	import entropy_pkg::*;

	coef_t store [BLOCK_SIZE];
	logic q_sel;
	logic [IDX_W-1:0] pos;
	logic [2:0] exp_val;
	coef_t scaled;

	assign pos = ZIGZAG[coef_index];
	assign exp_val = QUANT_EXP[q_sel][pos];
	assign scaled = coef_value <<< exp_val;

	always_ff @(posedge Clock) begin
		if (start) begin
			q_sel <= q_select; // Table stays fixed for the whole block
		end
		if (coef_valid) begin
			store[pos] <= scaled;
		end
		rd_data <= store[rd_addr];
	end

endmodule

//--- verilog/entropy_decode_top.sv
module entropy_decode_top #(
	parameter int MEM_LATENCY = 2
) (
	input  logic Clock,
	input  logic Resetn,
	input  logic start,
	input  logic q_select,
	output logic [entropy_pkg::ADDR_W-1:0] mem_addr,
	output logic mem_rd,
	input  logic [entropy_pkg::WORD_W-1:0] mem_data,
	output logic block_ready,
	input  logic [entropy_pkg::IDX_W-1:0] rd_addr,
	output entropy_pkg::coef_t rd_data
);
	import entropy_pkg::*;

	logic hold;
	logic code_valid;
	code_kind_t code_kind;
	coef_t value_a;
	coef_t value_b;
	logic [3:0] run_len;
	logic coef_valid;
	logic [IDX_W-1:0] coef_index;
	coef_t coef_value;

	bit_stream_if bits ();

	bit_window #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_window (
		.Clock(Clock),
		.Resetn(Resetn),
		.mem_addr(mem_addr),
		.mem_rd(mem_rd),
		.mem_data(mem_data),
		.win(bits.producer)
	);

	vlc_decoder u_vlc (
		.Clock(Clock),
		.Resetn(Resetn),
		.hold(hold),
		.win(bits.consumer),
		.code_valid(code_valid),
		.code_kind(code_kind),
		.value_a(value_a),
		.value_b(value_b),
		.run_len(run_len)
	);

	coeff_sequencer u_seq (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.code_valid(code_valid),
		.code_kind(code_kind),
		.value_a(value_a),
		.value_b(value_b),
		.run_len(run_len),
		.hold(hold),
		.coef_valid(coef_valid),
		.coef_index(coef_index),
		.coef_value(coef_value),
		.block_ready(block_ready)
	);

	dequantizer u_deq (
		.Clock(Clock),
		.start(start),
		.q_select(q_select),
		.coef_valid(coef_valid),
		.coef_index(coef_index),
		.coef_value(coef_value),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic Clock,
	output logic Resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		Clock = 1'b0;
		forever #(PERIOD_NS / 2) Clock = ~Clock;
	end

	// Released on a rising edge, so the flops still see reset at that edge
	initial begin
		Resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		Resetn <= 1'b1;
	end

endmodule

//--- test/tb_entropy_decode.sv
module tb_entropy_decode;
	timeunit 1ns;
	timeprecision 100ps;
	import entropy_pkg::*;

	localparam int MEM_LATENCY = 2;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_BLOCKS = 16;
	localparam int CYCLES_PER_BLOCK = 2000;
	localparam int MEM_WORDS = 2048;
	localparam int K_PAIR3 = 0;
	localparam int K_SINGLE3 = 1;
	localparam int K_SINGLE6 = 2;
	localparam int K_END_ZEROS = 3;
	localparam int K_SINGLE9 = 4;
	localparam int K_ZERO_RUN = 5;

	logic Clock;
	logic Resetn;
	logic start;
	logic q_select;
	logic [ADDR_W-1:0] mem_addr;
	logic mem_rd;
	logic [WORD_W-1:0] mem_data;
	logic block_ready;
	logic [IDX_W-1:0] rd_addr;
	coef_t rd_data;

	logic [WORD_W-1:0] memory [MEM_WORDS];
	logic [WORD_W-1:0] data_pipe [MEM_LATENCY];
	logic [15:0] lfsr_state;
	int code_kinds [$];
	int code_a [$];
	int code_b [$];
	int block_first [NUM_BLOCKS];
	int block_q [NUM_BLOCKS];
	string block_name [NUM_BLOCKS];
	int num_blocks;
	int coef_count;
	int bit_pos;
	int blocks_done;
	int test_errors;
	int total_errors;

	tb_clock_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(RESET_CYCLES)
	) u_clock (
		.Clock(Clock),
		.Resetn(Resetn)
	);

	entropy_decode_top #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_dut (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.q_select(q_select),
		.mem_addr(mem_addr),
		.mem_rd(mem_rd),
		.mem_data(mem_data),
		.block_ready(block_ready),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// Read data comes back MEM_LATENCY cycles after a cycle with mem_rd high
	always @(posedge Clock) begin
		data_pipe[0] <= mem_rd ? memory[mem_addr[$clog2(MEM_WORDS)-1:0]] : 'x;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i - 1];
		end
	end
	assign mem_data = data_pipe[MEM_LATENCY-1];

	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int random_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state); // One step per bit taken
		end
		return v;
	endfunction

	function automatic int to_signed(int v, int n);
		return (v >= (1 << (n - 1))) ? v - (1 << n) : v;
	endfunction

	// Standard zigzag walk over the anti-diagonals, starting along the top row
	function automatic int zigzag_pos(int scan);
		int k;
		int lo;
		int hi;
		int row;
		k = 0;
		for (int s = 0; s < 15; s++) begin
			lo = (s > 7) ? s - 7 : 0;
			hi = (s < 7) ? s : 7;
			for (int i = 0; i <= hi - lo; i++) begin
				row = (s % 2 == 0) ? hi - i : lo + i;
				if (k == scan) return row * 8 + (s - row);
				k++;
			end
		end
		return -1;
	endfunction

	function automatic int quant_shift(int q, int pos);
		int d;
		d = pos / 8 + pos % 8;
		if (q == 0) return (d < 12) ? d / 4 + 3 : 6;
		return (d < 10) ? d / 2 + 1 : 6;
	endfunction

	// Expected store content at row-major position pos once block blk is decoded
	function automatic int expected_value(int blk, int pos);
		int scan;
		int code;
		int found;
		int values [$];
		scan = 0;
		found = 0;
		code = block_first[blk];
		while (scan < BLOCK_SIZE && code < code_kinds.size()) begin
			values.delete();
			case (code_kinds[code])
				K_PAIR3: begin
					values.push_back(code_a[code]);
					values.push_back(code_b[code]);
				end
				K_END_ZEROS: repeat (BLOCK_SIZE - scan) values.push_back(0);
				K_ZERO_RUN: repeat ((code_a[code] == 0) ? 8 : code_a[code]) values.push_back(0);
				default: values.push_back(code_a[code]);
			endcase
			foreach (values[i]) begin
				if (scan < BLOCK_SIZE && zigzag_pos(scan) == pos) found = values[i];
				scan++; // Values past index 63 fall off here
			end
			code++;
		end
		return found << quant_shift(block_q[blk], pos);
	endfunction

	task automatic check_value(string name, logic signed [31:0] got,
			logic signed [31:0] expected);
		if (got !== expected) begin
			$display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic put_bits(int value, int n);
		for (int i = n - 1; i >= 0; i--) begin
			memory[bit_pos / WORD_W][WORD_W - 1 - bit_pos % WORD_W] = value[i];
			bit_pos++;
		end
	endtask

	task automatic add_code(int kind, int a, int b);
		code_kinds.push_back(kind);
		code_a.push_back(a);
		code_b.push_back(b);
		coef_count += (kind == K_PAIR3) ? 2 :
			(kind == K_ZERO_RUN) ? ((a == 0) ? 8 : a) :
			(kind == K_END_ZEROS) ? BLOCK_SIZE : 1;
		case (kind)
			K_PAIR3: put_bits({2'b00, 3'(a), 3'(b)}, 8);
			K_SINGLE3: put_bits({2'b01, 3'(a)}, 5);
			K_SINGLE6: put_bits({3'b100, 6'(a)}, 9);
			K_END_ZEROS: put_bits(4'b1010, 4);
			K_SINGLE9: put_bits({4'b1011, 9'(a)}, 13);
			default: put_bits({2'b11, 3'(a)}, 5);
		endcase
	endtask

	task automatic add_random_code(int kind);
		int width;
		int a;
		int b;
		width = (kind == K_SINGLE6) ? 6 : (kind == K_SINGLE9) ? 9 : 3;
		a = random_bits(width);
		b = to_signed(random_bits(3), 3);
		if (kind != K_ZERO_RUN) a = to_signed(a, width);
		add_code(kind, a, b);
	endtask

	task automatic start_block(string name, int q);
		block_first[num_blocks] = code_kinds.size();
		block_q[num_blocks] = q;
		block_name[num_blocks] = name;
		num_blocks++;
		coef_count = 0;
	endtask

	task automatic add_random_block();
		int r;
		start_block("random codes", random_bits(1));
		while (coef_count < BLOCK_SIZE) begin
			r = random_bits(4);
			if (r == 15) add_random_code(K_END_ZEROS); // Rare, so most blocks run to the end
			else add_random_code((r % 5 >= K_END_ZEROS) ? r % 5 + 1 : r % 5);
		end
	endtask

	task automatic build_stream();
		int r;
		foreach (memory[i]) memory[i] = '0;
		bit_pos = 0;
		num_blocks = 0;
		lfsr_state = 16'd64840;
		start_block("singles", 0);
		while (coef_count < BLOCK_SIZE) begin
			r = random_bits(2) % 3;
			add_random_code((r == 0) ? K_SINGLE3 : (r == 1) ? K_SINGLE6 : K_SINGLE9);
		end
		start_block("pairs and zero runs", 0);
		for (int n = 0; n < 8; n++) add_code(K_ZERO_RUN, n, 0);
		add_random_code(K_SINGLE3);
		repeat (12) add_random_code(K_PAIR3);
		add_code(K_ZERO_RUN, 0, 0); // Starts at index 61, five zeros overflow
		start_block("pair past the end", 0);
		repeat (63) add_random_code(K_SINGLE3);
		add_code(K_PAIR3, -3, 2);
		start_block("end of block at index 63", 0);
		repeat (63) add_random_code(K_SINGLE3);
		add_code(K_END_ZEROS, 0, 0);
		start_block("early end of block", 0);
		repeat (20) add_random_code(K_SINGLE6);
		add_code(K_END_ZEROS, 0, 0);
		start_block("singles again", 1);
		for (int i = block_first[0]; i < block_first[1]; i++) begin
			add_code(code_kinds[i], code_a[i], code_b[i]);
		end
		repeat (10) add_random_block();
	endtask

	initial begin : drive_blocks
		start = 1'b0;
		q_select = 1'b0;
		foreach (data_pipe[i]) data_pipe[i] = '0;
		build_stream();
		wait (Resetn === 1'b1);
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			wait (blocks_done == b);
			@(posedge Clock);
			start <= 1'b1;
			q_select <= block_q[b][0];
			@(posedge Clock);
			start <= 1'b0;
		end
	end

	initial begin : compare_blocks
		rd_addr = '0;
		blocks_done = 0;
		total_errors = 0;
		test_errors = 0;
		wait (Resetn === 1'b1);
		@(negedge Clock);
		check_value("block_ready", block_ready, 0);
		$display("Reset state: %0d errors", test_errors);
		total_errors += test_errors;
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			test_errors = 0;
			@(negedge Clock);
			while (start !== 1'b1) @(negedge Clock);
			@(negedge Clock);
			check_value("block_ready", block_ready, 0); // Start was taken at the last edge
			while (block_ready !== 1'b1) @(negedge Clock);
			for (int a = 0; a < BLOCK_SIZE; a++) begin
				@(posedge Clock);
				rd_addr <= IDX_W'(a);
				@(negedge Clock);
				@(negedge Clock);
				check_value($sformatf("rd_data[%0d]", a), rd_data, expected_value(b, a));
			end
			check_value("block_ready", block_ready, 1);
			$display("Block %0d (%s, table %0d): %0d errors", b, block_name[b], block_q[b],
				test_errors);
			total_errors += test_errors;
			blocks_done = b + 1;
		end
		$display("Summary: %0d tests, %0d errors", NUM_BLOCKS + 1, total_errors);
		if (total_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (RESET_CYCLES + NUM_BLOCKS * CYCLES_PER_BLOCK) @(posedge Clock);
		$display("Timeout: the decoder never raised block_ready after %0d blocks", blocks_done);
		$display("test failed");
		$finish;
	end

endmodule

//--- block_entropy_decoder.f
verilog/entropy_pkg.sv
verilog/bit_stream_if.sv
verilog/bit_window.sv
verilog/vlc_decoder.sv
verilog/coeff_sequencer.sv
verilog/dequantizer.sv
verilog/entropy_decode_top.sv
test/tb_clock_gen.sv
test/tb_entropy_decode.sv
